/* Bender.yml */
package:
  name: ctrl_cluster

sources:
  - ctrl_pkg.sv
  - ctrl_bus_arbiter.sv
  - ctrl_reg_file.sv
  - wake_up_unit.sv
  - ctrl_cluster_top.sv
  - target: test
    files:
      - tb_ctrl_cluster.sv

/* all.f */
ctrl_pkg.sv
ctrl_bus_arbiter.sv
ctrl_reg_file.sv
wake_up_unit.sv
ctrl_cluster_top.sv
tb_ctrl_cluster.sv

/* ctrl_bus_arbiter.sv */
////////////////////
// Round-robin arbiter between the host and debug register ports
////////////////////

`timescale 1ns/1ns

module ctrl_bus_arbiter (
  input  logic                          clk_i,
  input  logic                          rst_i,
  // Host port
  input  logic                          host_req_i,
  input  logic                          host_we_i,
  input  logic [ctrl_pkg::AddrWidth-1:0] host_addr_i,
  input  logic [ctrl_pkg::DataWidth-1:0] host_wdata_i,
  output logic                          host_gnt_o,
  output logic                          host_rvalid_o,
  output logic [ctrl_pkg::DataWidth-1:0] host_rdata_o,
  // Debug port
  input  logic                          dbg_req_i,
  input  logic                          dbg_we_i,
  input  logic [ctrl_pkg::AddrWidth-1:0] dbg_addr_i,
  input  logic [ctrl_pkg::DataWidth-1:0] dbg_wdata_i,
  output logic                          dbg_gnt_o,
  output logic                          dbg_rvalid_o,
  output logic [ctrl_pkg::DataWidth-1:0] dbg_rdata_o,
  // Shared register bus
  output logic                          reg_valid_o,
  output logic                          reg_we_o,
  output logic [ctrl_pkg::AddrWidth-1:0] reg_addr_o,
  output logic [ctrl_pkg::DataWidth-1:0] reg_wdata_o,
  input  logic [ctrl_pkg::DataWidth-1:0] reg_rdata_i
);

  import ctrl_pkg::*;

  // Set when the host won the most recent grant
  logic host_last_q;
  logic host_rvalid_q, dbg_rvalid_q;

  // Host wins unless the debug port also asks and host was served last
  assign host_gnt_o = host_req_i & (~dbg_req_i | ~host_last_q);
  assign dbg_gnt_o  = dbg_req_i & ~host_gnt_o;

  assign reg_valid_o = host_gnt_o | dbg_gnt_o;
  assign reg_we_o    = host_gnt_o ? host_we_i    : dbg_we_i;
  assign reg_addr_o  = host_gnt_o ? host_addr_i  : dbg_addr_i;
  assign reg_wdata_o = host_gnt_o ? host_wdata_i : dbg_wdata_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      host_last_q   <= 1'b0;
      host_rvalid_q <= 1'b0;
      dbg_rvalid_q  <= 1'b0;
    end else begin
      if (reg_valid_o) begin
        host_last_q <= host_gnt_o;
      end
      host_rvalid_q <= host_gnt_o;
      dbg_rvalid_q  <= dbg_gnt_o;
    end
  end

  // Response goes back only to the port that was granted
  assign host_rvalid_o = host_rvalid_q;
  assign dbg_rvalid_o  = dbg_rvalid_q;
  assign host_rdata_o  = host_rvalid_q ? reg_rdata_i : '0;
  assign dbg_rdata_o   = dbg_rvalid_q ? reg_rdata_i : '0;

  a_gnt_exclusive: assert property (@(posedge clk_i) disable iff (rst_i)
    !(host_gnt_o && dbg_gnt_o))
    else $error("Host and debug ports granted in the same cycle");

  a_host_resp: assert property (@(posedge clk_i) disable iff (rst_i)
    host_gnt_o |=> host_rvalid_o && !dbg_rvalid_o)
    else $error("Host grant not answered on the host port one cycle later");

  a_dbg_resp: assert property (@(posedge clk_i) disable iff (rst_i)
    dbg_gnt_o |=> dbg_rvalid_o && !host_rvalid_o)
    else $error("Debug grant not answered on the debug port one cycle later");

endmodule : ctrl_bus_arbiter

/* ctrl_cluster_top.sv */
////////////////////
// Cluster control block top level
////////////////////

`timescale 1ns/1ns

module ctrl_cluster_top (
  input  logic                          clk_i,
  input  logic                          rst_i,
  // Host port
  input  logic                          host_req_i,
  input  logic                          host_we_i,
  input  logic [ctrl_pkg::AddrWidth-1:0] host_addr_i,
  input  logic [ctrl_pkg::DataWidth-1:0] host_wdata_i,
  output logic                          host_gnt_o,
  output logic                          host_rvalid_o,
  output logic [ctrl_pkg::DataWidth-1:0] host_rdata_o,
  // Debug port
  input  logic                          dbg_req_i,
  input  logic                          dbg_we_i,
  input  logic [ctrl_pkg::AddrWidth-1:0] dbg_addr_i,
  input  logic [ctrl_pkg::DataWidth-1:0] dbg_wdata_i,
  output logic                          dbg_gnt_o,
  output logic                          dbg_rvalid_o,
  output logic [ctrl_pkg::DataWidth-1:0] dbg_rdata_o,
  // Cluster control outputs
  output logic [ctrl_pkg::DataWidth-1:0] eoc_o,
  output logic                          eoc_valid_o,
  output logic [ctrl_pkg::NumCores-1:0]  wake_up_o,
  output logic                          ro_cache_enable_o,
  output logic                          ro_cache_flush_o,
  output logic [ctrl_pkg::RoCacheNumRules-1:0][ctrl_pkg::DataWidth-1:0] ro_cache_start_o,
  output logic [ctrl_pkg::RoCacheNumRules-1:0][ctrl_pkg::DataWidth-1:0] ro_cache_end_o
);

  import ctrl_pkg::*;

  logic                 reg_valid, reg_we;
  logic [AddrWidth-1:0] reg_addr;
  logic [DataWidth-1:0] reg_wdata, reg_rdata;
  logic                 wake_core_we, wake_group_we, mask_we;
  logic [DataWidth-1:0] wake_core, wake_group, wake_strd, wake_offst;

  ctrl_bus_arbiter i_bus_arbiter (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .host_req_i   (host_req_i),
    .host_we_i    (host_we_i),
    .host_addr_i  (host_addr_i),
    .host_wdata_i (host_wdata_i),
    .host_gnt_o   (host_gnt_o),
    .host_rvalid_o(host_rvalid_o),
    .host_rdata_o (host_rdata_o),
    .dbg_req_i    (dbg_req_i),
    .dbg_we_i     (dbg_we_i),
    .dbg_addr_i   (dbg_addr_i),
    .dbg_wdata_i  (dbg_wdata_i),
    .dbg_gnt_o    (dbg_gnt_o),
    .dbg_rvalid_o (dbg_rvalid_o),
    .dbg_rdata_o  (dbg_rdata_o),
    .reg_valid_o  (reg_valid),
    .reg_we_o     (reg_we),
    .reg_addr_o   (reg_addr),
    .reg_wdata_o  (reg_wdata),
    .reg_rdata_i  (reg_rdata)
  );

  ctrl_reg_file i_reg_file (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .reg_valid_i      (reg_valid),
    .reg_we_i         (reg_we),
    .reg_addr_i       (reg_addr),
    .reg_wdata_i      (reg_wdata),
    .reg_rdata_o      (reg_rdata),
    .eoc_o            (eoc_o),
    .eoc_valid_o      (eoc_valid_o),
    .ro_cache_enable_o(ro_cache_enable_o),
    .ro_cache_flush_o (ro_cache_flush_o),
    .ro_cache_start_o (ro_cache_start_o),
    .ro_cache_end_o   (ro_cache_end_o),
    .wake_core_we_o   (wake_core_we),
    .wake_group_we_o  (wake_group_we),
    .mask_we_o        (mask_we),
    .wake_core_o      (wake_core),
    .wake_group_o     (wake_group),
    .wake_strd_o      (wake_strd),
    .wake_offst_o     (wake_offst)
  );

  wake_up_unit i_wake_up_unit (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .wake_core_we_i (wake_core_we),
    .wake_group_we_i(wake_group_we),
    .mask_we_i      (mask_we),
    .wake_core_i    (wake_core),
    .wake_group_i   (wake_group),
    .wake_strd_i    (wake_strd),
    .wake_offst_i   (wake_offst),
    .wake_up_o      (wake_up_o)
  );

endmodule : ctrl_cluster_top

/* ctrl_pkg.sv */
////////////////////
// Cluster geometry, register offsets and cache region reset values
////////////////////

package ctrl_pkg;

  // Bus geometry
  localparam int DataWidth = 32;
  localparam int AddrWidth = 8;

  // Cluster geometry
  localparam int NumGroups        = 4;
  localparam int NumCoresPerGroup = 4;
  localparam int NumCores         = NumGroups * NumCoresPerGroup;
  localparam int CoreIdxWidth     = $clog2(NumCores);

  // Tightly coupled data memory window
  localparam logic [DataWidth-1:0] TcdmBaseAddr = 32'h0000_0000;
  localparam logic [DataWidth-1:0] TcdmSize     = 32'h0001_0000;

  // Read-only cache regions, index 0 sits in the low word
  localparam int RoCacheNumRules = 2;
  localparam logic [RoCacheNumRules-1:0][DataWidth-1:0] RoCacheStartReset = {
    32'hA000_0000, 32'h8000_0000
  };
  localparam logic [RoCacheNumRules-1:0][DataWidth-1:0] RoCacheEndReset = {
    32'hA000_1000, 32'h8000_1000
  };

  // Register byte offsets
  localparam logic [AddrWidth-1:0] EocOffset           = 8'h00;
  localparam logic [AddrWidth-1:0] NrCoresOffset       = 8'h04;
  localparam logic [AddrWidth-1:0] TcdmStartOffset     = 8'h08;
  localparam logic [AddrWidth-1:0] TcdmEndOffset       = 8'h0C;
  localparam logic [AddrWidth-1:0] WakeUpOffset        = 8'h10;
  localparam logic [AddrWidth-1:0] WakeUpGroupOffset   = 8'h14;
  localparam logic [AddrWidth-1:0] WakeUpStrdOffset    = 8'h18;
  localparam logic [AddrWidth-1:0] WakeUpOffstOffset   = 8'h1C;
  localparam logic [AddrWidth-1:0] RoCacheEnableOffset = 8'h20;
  localparam logic [AddrWidth-1:0] RoCacheFlushOffset  = 8'h24;
  // Rule i lives at base + RoCacheRuleStride * i
  localparam logic [AddrWidth-1:0] RoCacheStartOffset  = 8'h28;
  localparam logic [AddrWidth-1:0] RoCacheEndOffset    = 8'h2C;
  localparam logic [AddrWidth-1:0] RoCacheRuleStride   = 8'h08;

endpackage : ctrl_pkg

/* ctrl_reg_file.sv */
////////////////////
// Control register storage, read mux and wake-up write strobes
////////////////////

`timescale 1ns/1ns

module ctrl_reg_file (
  input  logic                           clk_i,
  input  logic                           rst_i,
  // Granted access from the arbiter
  input  logic                           reg_valid_i,
  input  logic                           reg_we_i,
  input  logic [ctrl_pkg::AddrWidth-1:0]  reg_addr_i,
  input  logic [ctrl_pkg::DataWidth-1:0]  reg_wdata_i,
  output logic [ctrl_pkg::DataWidth-1:0]  reg_rdata_o,
  // End of computation
  output logic [ctrl_pkg::DataWidth-1:0]  eoc_o,
  output logic                           eoc_valid_o,
  // Read-only cache control
  output logic                           ro_cache_enable_o,
  output logic                           ro_cache_flush_o,
  output logic [ctrl_pkg::RoCacheNumRules-1:0][ctrl_pkg::DataWidth-1:0] ro_cache_start_o,
  output logic [ctrl_pkg::RoCacheNumRules-1:0][ctrl_pkg::DataWidth-1:0] ro_cache_end_o,
  // Toward the wake-up unit
  output logic                           wake_core_we_o,
  output logic                           wake_group_we_o,
  output logic                           mask_we_o,
  output logic [ctrl_pkg::DataWidth-1:0]  wake_core_o,
  output logic [ctrl_pkg::DataWidth-1:0]  wake_group_o,
  output logic [ctrl_pkg::DataWidth-1:0]  wake_strd_o,
  output logic [ctrl_pkg::DataWidth-1:0]  wake_offst_o
);

  import ctrl_pkg::*;

  logic                 wr_en;
  logic [DataWidth-1:0] rdata_d, rdata_q;
  logic [DataWidth-1:0] eoc_q, enable_q, flush_q;
  logic [DataWidth-1:0] wake_core_q, wake_group_q, wake_strd_q, wake_offst_q;
  logic [RoCacheNumRules-1:0][DataWidth-1:0] ro_start_q, ro_end_q;
  logic [RoCacheNumRules-1:0] start_hit, end_hit;
  logic wake_core_we_q, wake_group_we_q, mask_we_q;

  assign wr_en = reg_valid_i & reg_we_i;

  // Address match for each cache rule
  always_comb begin
    for (int i = 0; i < RoCacheNumRules; i++) begin
      start_hit[i] = reg_addr_i == AddrWidth'(RoCacheStartOffset + RoCacheRuleStride * i);
      end_hit[i]   = reg_addr_i == AddrWidth'(RoCacheEndOffset + RoCacheRuleStride * i);
    end
  end

  // Read mux, unmapped offsets return zero
  always_comb begin
    rdata_d = '0;
    case (reg_addr_i)
      EocOffset:           rdata_d = eoc_q;
      NrCoresOffset:       rdata_d = DataWidth'(NumCores);
      TcdmStartOffset:     rdata_d = TcdmBaseAddr;
      TcdmEndOffset:       rdata_d = TcdmBaseAddr + TcdmSize;
      WakeUpOffset:        rdata_d = wake_core_q;
      WakeUpGroupOffset:   rdata_d = wake_group_q;
      WakeUpStrdOffset:    rdata_d = wake_strd_q;
      WakeUpOffstOffset:   rdata_d = wake_offst_q;
      RoCacheEnableOffset: rdata_d = enable_q;
      RoCacheFlushOffset:  rdata_d = flush_q;
      default:             rdata_d = '0;
    endcase
    for (int i = 0; i < RoCacheNumRules; i++) begin
      if (start_hit[i]) begin
        rdata_d = ro_start_q[i];
      end
      if (end_hit[i]) begin
        rdata_d = ro_end_q[i];
      end
    end
  end

  // Read data is captured on every granted access
  always_ff @(posedge clk_i) begin
    if (reg_valid_i) begin
      rdata_q <= rdata_d;
    end
  end

  // Writable registers, the fixed ones above ignore writes
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      eoc_q        <= '0;
      enable_q     <= '0;
      flush_q      <= '0;
      wake_core_q  <= '0;
      wake_group_q <= '0;
      wake_strd_q  <= '0;
      wake_offst_q <= '0;
      ro_start_q   <= RoCacheStartReset;
      ro_end_q     <= RoCacheEndReset;
    end else if (wr_en) begin
      case (reg_addr_i)
        EocOffset:           eoc_q        <= reg_wdata_i;
        WakeUpOffset:        wake_core_q  <= reg_wdata_i;
        WakeUpGroupOffset:   wake_group_q <= reg_wdata_i;
        WakeUpStrdOffset:    wake_strd_q  <= reg_wdata_i;
        WakeUpOffstOffset:   wake_offst_q <= reg_wdata_i;
        RoCacheEnableOffset: enable_q     <= reg_wdata_i;
        RoCacheFlushOffset:  flush_q      <= reg_wdata_i;
        default:             eoc_q        <= eoc_q;
      endcase
      for (int i = 0; i < RoCacheNumRules; i++) begin
        if (start_hit[i]) begin
          ro_start_q[i] <= reg_wdata_i;
        end
        if (end_hit[i]) begin
          ro_end_q[i] <= reg_wdata_i;
        end
      end
    end
  end

  // Strobes line up with the freshly stored values
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wake_core_we_q  <= 1'b0;
      wake_group_we_q <= 1'b0;
      mask_we_q       <= 1'b0;
    end else begin
      wake_core_we_q  <= wr_en && (reg_addr_i == WakeUpOffset);
      wake_group_we_q <= wr_en && (reg_addr_i == WakeUpGroupOffset);
      mask_we_q       <= wr_en && (reg_addr_i == WakeUpStrdOffset ||
                                   reg_addr_i == WakeUpOffstOffset);
    end
  end

  assign reg_rdata_o       = rdata_q;
  assign eoc_o             = eoc_q >> 1;
  assign eoc_valid_o       = eoc_q[0];
  assign ro_cache_enable_o = enable_q[0];
  assign ro_cache_flush_o  = flush_q[0];
  assign ro_cache_start_o  = ro_start_q;
  assign ro_cache_end_o    = ro_end_q;
  assign wake_core_we_o    = wake_core_we_q;
  assign wake_group_we_o   = wake_group_we_q;
  assign mask_we_o         = mask_we_q;
  assign wake_core_o       = wake_core_q;
  assign wake_group_o      = wake_group_q;
  assign wake_strd_o       = wake_strd_q;
  assign wake_offst_o      = wake_offst_q;

  // Strobe comes after a write and sees the value that write stored
  a_strobe_after_write: assert property (@(posedge clk_i) disable iff (rst_i)
    (wake_core_we_o || wake_group_we_o || mask_we_o) |->
      $past(reg_valid_i && reg_we_i) &&
      (!wake_core_we_o || wake_core_o == $past(reg_wdata_i)) &&
      (!wake_group_we_o || wake_group_o == $past(reg_wdata_i)))
    else $error("Wake-up strobe raised without a matching write in the previous cycle");

endmodule : ctrl_reg_file

/* tb_ctrl_cluster.sv */
////////////////////
// Testbench for the cluster control block with bus tasks,
// reference models for wake-up pulses, checks and watchdog
////////////////////

`timescale 1ns/1ns

module tb_ctrl_cluster;

  import ctrl_pkg::*;

  // Roughly 120 bus accesses of two or three cycles each, with a wide margin
  localparam int WatchdogCycles = 2000;
  localparam int ArbRounds      = 4;
  localparam logic [AddrWidth-1:0] RwOffsets [9] = '{
    8'h28, 8'h2C, 8'h30, 8'h34, 8'h20, 8'h24, 8'h00, 8'h00, 8'h20
  };

  logic clk_i, rst_i;
  logic host_req_i, host_we_i, dbg_req_i, dbg_we_i;
  logic [AddrWidth-1:0] host_addr_i, dbg_addr_i;
  logic [DataWidth-1:0] host_wdata_i, dbg_wdata_i;
  logic host_gnt_o, host_rvalid_o, dbg_gnt_o, dbg_rvalid_o;
  logic [DataWidth-1:0] host_rdata_o, dbg_rdata_o, eoc_o;
  logic eoc_valid_o, ro_cache_enable_o, ro_cache_flush_o;
  logic [NumCores-1:0] wake_up_o;
  logic [RoCacheNumRules-1:0][DataWidth-1:0] ro_cache_start_o, ro_cache_end_o;

  int unsigned cyc;
  int val_errors, proto_errors;
  string test_name;
  logic [NumCores-1:0] mask_model;
  logic [DataWidth-1:0] strd_model, offst_model;
  // Expected wake-up vector, keyed by the cycle in which it must show
  logic [NumCores-1:0] exp_wake [int unsigned];
  bit arb_active;
  bit owner_q [$];

  ctrl_cluster_top dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cyc <= cyc + 1;

  // Every other cycle must show no pulse at all
  always @(negedge clk_i) begin : wake_monitor
    logic [NumCores-1:0] exp_now;
    if (!rst_i) begin
      exp_now = exp_wake.exists(cyc) ? exp_wake[cyc] : '0;
      check_value("wake_up_o", exp_now, wake_up_o);
    end
  end

  // Order in which the ports were served, 1 for debug
  always @(negedge clk_i) begin
    if (arb_active && (host_rvalid_o || dbg_rvalid_o)) begin
      owner_q.push_back(dbg_rvalid_o);
    end
  end

  a_one_grant: assert property (@(posedge clk_i) disable iff (rst_i)
    !(host_gnt_o && dbg_gnt_o))
    else begin
      proto_errors++;
      $display("Host and debug ports were granted in the same cycle");
    end

  a_rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (rst_i)
    (host_rvalid_o || dbg_rvalid_o) |-> $past(host_gnt_o || dbg_gnt_o))
    else begin
      proto_errors++;
      $display("A read-valid pulse came without a grant one cycle before");
    end

  function automatic logic [NumCores-1:0] single_core_target(input logic [DataWidth-1:0] k);
    if (k < NumCores) begin
      return NumCores'(1) << k;
    end
    return '1;
  endfunction

  function automatic logic [NumCores-1:0] group_target(input logic [DataWidth-1:0] g);
    logic [NumCores-1:0] m;
    m = '0;
    if (g == '1) begin
      m = '1;
    end else if (g < (1 << NumGroups)) begin
      for (int i = 0; i < NumCores; i++) begin
        m[i] = g[i / NumCoresPerGroup];
      end
    end
    return m;
  endfunction

  function automatic logic [NumCores-1:0] stride_mask(input logic [DataWidth-1:0] strd,
                                                      input logic [DataWidth-1:0] offst);
    logic [NumCores-1:0] m;
    longint unsigned c;
    m = '0;
    c = offst;
    while (c < NumCores) begin
      m[c] = 1'b1;
      if (strd == 0) begin
        break;
      end
      c = c + strd;
    end
    return m;
  endfunction

  task automatic check_value(input string what, input logic [DataWidth-1:0] expected,
                             input logic [DataWidth-1:0] actual);
    assert (actual === expected) else begin
      val_errors++;
      $display("Fail %s %s: expected %h, actual %h", test_name, what, expected, actual);
    end
  endtask

  task automatic apply_reset();
    rst_i = 1'b1;
    repeat (4) @(negedge clk_i);
    rst_i       = 1'b0;
    mask_model  = '1;
    strd_model  = '0;
    offst_model = '0;
    exp_wake.delete();
  endtask

  // Called on a falling edge, returns on the falling edge after the grant edge
  task automatic access_port(input bit dbg, input logic we, input logic [AddrWidth-1:0] addr,
                             input logic [DataWidth-1:0] wdata,
                             output logic [DataWidth-1:0] rdata);
    bit done;
    done = 1'b0;
    if (dbg) begin
      dbg_req_i   = 1'b1;
      dbg_we_i    = we;
      dbg_addr_i  = addr;
      dbg_wdata_i = wdata;
    end else begin
      host_req_i   = 1'b1;
      host_we_i    = we;
      host_addr_i  = addr;
      host_wdata_i = wdata;
    end
    while (!done) begin
      @(negedge clk_i);
      done = dbg ? dbg_rvalid_o : host_rvalid_o;
    end
    rdata = dbg ? dbg_rdata_o : host_rdata_o;
    if (dbg) begin
      dbg_req_i = 1'b0;
    end else begin
      host_req_i = 1'b0;
    end
  endtask

  task automatic read_reg(input bit dbg, input logic [AddrWidth-1:0] addr,
                          output logic [DataWidth-1:0] rdata);
    access_port(dbg, 1'b0, addr, '0, rdata);
  endtask

  task automatic write_reg(input bit dbg, input logic [AddrWidth-1:0] addr,
                           input logic [DataWidth-1:0] value);
    logic [DataWidth-1:0] rsp;
    access_port(dbg, 1'b1, addr, value, rsp);
    // One cycle of strobe, then the registered pulse
    if (addr == WakeUpOffset) begin
      exp_wake[cyc + 1] = single_core_target(value) & mask_model;
    end else if (addr == WakeUpGroupOffset) begin
      exp_wake[cyc + 1] = group_target(value) & mask_model;
    end else if (addr == WakeUpStrdOffset) begin
      strd_model = value;
      mask_model = stride_mask(strd_model, offst_model);
    end else if (addr == WakeUpOffstOffset) begin
      offst_model = value;
      mask_model  = stride_mask(strd_model, offst_model);
    end
  endtask

  task automatic port_traffic(input bit dbg, input logic [AddrWidth-1:0] addr);
    logic [DataWidth-1:0] w, r;
    for (int i = 0; i < ArbRounds; i++) begin
      w = $urandom();
      write_reg(dbg, addr, w);
      read_reg(dbg, addr, r);
      check_value(dbg ? "debug read back" : "host read back", w, r);
    end
  endtask

  initial begin
    repeat (WatchdogCycles) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, a bus access never completed",
             WatchdogCycles);
    $display("Regression failed");
    $finish;
  end

  initial begin
    logic [DataWidth-1:0] w, r;
    logic [AddrWidth-1:0] a;
    int unsigned rule;
    void'($urandom(32'h98bc));
    host_req_i   = 1'b0;
    host_we_i    = 1'b0;
    host_addr_i  = '0;
    host_wdata_i = '0;
    dbg_req_i    = 1'b0;
    dbg_we_i     = 1'b0;
    dbg_addr_i   = '0;
    dbg_wdata_i  = '0;
    cyc          = 0;
    val_errors   = 0;
    proto_errors = 0;
    arb_active   = 1'b0;
    apply_reset();

    test_name = "reset";
    check_value("eoc_valid_o", 1'b0, eoc_valid_o);
    check_value("ro_cache_enable_o", 1'b0, ro_cache_enable_o);
    check_value("ro_cache_flush_o", 1'b0, ro_cache_flush_o);
    for (int i = 0; i < RoCacheNumRules; i++) begin
      check_value("ro_cache_start_o", RoCacheStartReset[i], ro_cache_start_o[i]);
      check_value("ro_cache_end_o", RoCacheEndReset[i], ro_cache_end_o[i]);
    end
    // Second round follows the writes to the read-only offsets
    for (int n = 0; n < 2; n++) begin
      read_reg(1'b0, NrCoresOffset, r);
      check_value("NrCores", NumCores, r);
      read_reg(1'b1, TcdmStartOffset, r);
      check_value("TcdmStart", TcdmBaseAddr, r);
      read_reg(1'b0, TcdmEndOffset, r);
      check_value("TcdmEnd", TcdmBaseAddr + TcdmSize, r);
      write_reg(1'b1, NrCoresOffset, $urandom());
      write_reg(1'b0, TcdmStartOffset, $urandom());
      write_reg(1'b1, TcdmEndOffset, $urandom());
    end
    read_reg(1'b0, 8'h38, r);
    check_value("unmapped 0x38", '0, r);
    read_reg(1'b1, 8'hFC, r);
    check_value("unmapped 0xFC", '0, r);

    test_name = "write_read";
    foreach (RwOffsets[i]) begin
      w = $urandom();
      a = RwOffsets[i];
      write_reg(i % 2, a, w);
      if (a == EocOffset) begin
        check_value("eoc_o", w >> 1, eoc_o);
        check_value("eoc_valid_o", w[0], eoc_valid_o);
      end else if (a == RoCacheEnableOffset) begin
        check_value("ro_cache_enable_o", w[0], ro_cache_enable_o);
      end else if (a == RoCacheFlushOffset) begin
        check_value("ro_cache_flush_o", w[0], ro_cache_flush_o);
      end else begin
        rule = (a - RoCacheStartOffset) / RoCacheRuleStride;
        check_value("cache region", w, a[2] ? ro_cache_end_o[rule] : ro_cache_start_o[rule]);
      end
      read_reg((i + 1) % 2, a, r);
      check_value("read back", w, r);
    end

    test_name = "core_wake";
    for (int k = 0; k < NumCores; k++) begin
      write_reg(k % 2, WakeUpOffset, k);
    end
    write_reg(1'b0, WakeUpOffset, NumCores);
    write_reg(1'b1, WakeUpOffset, $urandom() | 32'h100);

    test_name = "group_wake";
    for (int i = 0; i < 6; i++) begin
      write_reg(i % 2, WakeUpGroupOffset, $urandom_range(15, 0));
    end
    write_reg(1'b0, WakeUpGroupOffset, 32'hFFFF_FFFF);
    write_reg(1'b1, WakeUpGroupOffset, 32'h10);
    write_reg(1'b0, WakeUpGroupOffset, 32'h8000_0000);

    test_name = "stride_mask";
    for (int i = 0; i < 8; i++) begin
      write_reg(1'b0, WakeUpStrdOffset, (i == 6) ? 0 : $urandom_range(6, 0));
      write_reg(1'b1, WakeUpOffstOffset, (i == 7) ? NumCores + 2 : $urandom_range(17, 0));
      write_reg(1'b0, WakeUpOffset, NumCores);
      write_reg(1'b1, WakeUpGroupOffset, 32'hFFFF_FFFF);
      write_reg(1'b0, WakeUpOffset, $urandom_range(NumCores - 1, 0));
    end
    repeat (3) @(negedge clk_i);

    test_name = "arbitration";
    apply_reset();
    arb_active = 1'b1;
    fork
      port_traffic(1'b0, RoCacheStartOffset);
      port_traffic(1'b1, RoCacheEndOffset + RoCacheRuleStride);
    join
    @(negedge clk_i);
    arb_active = 1'b0;
    check_value("grant count", 4 * ArbRounds, owner_q.size());
    assert (owner_q.size() > 0 && owner_q[0] == 1'b0) else begin
      proto_errors++;
      $display("The debug port won the first grant after reset");
    end
    for (int i = 1; i < owner_q.size(); i++) begin
      assert (owner_q[i] != owner_q[i-1]) else begin
        proto_errors++;
        $display("Grants did not alternate at grant %0d", i);
      end
    end

    $display("Closing report: %0d value errors, %0d protocol errors", val_errors,
             proto_errors);
    if (val_errors == 0 && proto_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule : tb_ctrl_cluster

/* wake_up_unit.sv */
////////////////////
// Wake-up pulse generation with stride/offset core mask
////////////////////

`timescale 1ns/1ns

module wake_up_unit (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          wake_core_we_i,
  input  logic                          wake_group_we_i,
  input  logic                          mask_we_i,
  input  logic [ctrl_pkg::DataWidth-1:0] wake_core_i,
  input  logic [ctrl_pkg::DataWidth-1:0] wake_group_i,
  input  logic [ctrl_pkg::DataWidth-1:0] wake_strd_i,
  input  logic [ctrl_pkg::DataWidth-1:0] wake_offst_i,
  output logic [ctrl_pkg::NumCores-1:0]  wake_up_o
);

  import ctrl_pkg::*;

  logic [NumCores-1:0]    mask_d, mask_q;
  logic [NumCores-1:0]    raw;
  logic [NumCores-1:0]    wake_up_q;
  // Wide enough that offset plus stride times index never wraps
  logic [2*DataWidth-1:0] pos;

  // Cores offset, offset + stride, ... below NumCores
  always_comb begin
    mask_d = '0;
    pos    = '0;
    for (int k = 0; k < NumCores; k++) begin
      pos = (2*DataWidth)'(wake_offst_i) + (2*DataWidth)'(wake_strd_i) * (2*DataWidth)'(k);
      if (pos < (2*DataWidth)'(NumCores)) begin
        mask_d[pos[CoreIdxWidth-1:0]] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mask_q <= '1;
    end else if (mask_we_i) begin
      mask_q <= mask_d;
    end
  end

  // Unmasked wake-up request from the core and group registers
  always_comb begin
    raw = '0;
    if (wake_core_we_i) begin
      if (wake_core_i < DataWidth'(NumCores)) begin
        raw[wake_core_i[CoreIdxWidth-1:0]] = 1'b1;
      end else begin
        raw = '1;
      end
    end
    if (wake_group_we_i) begin
      if (wake_group_i <= DataWidth'({NumGroups{1'b1}})) begin
        for (int g = 0; g < NumGroups; g++) begin
          raw[g*NumCoresPerGroup +: NumCoresPerGroup] =
            raw[g*NumCoresPerGroup +: NumCoresPerGroup] |
            {NumCoresPerGroup{wake_group_i[g]}};
        end
      end else if (wake_group_i == '1) begin
        raw = '1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wake_up_q <= '0;
    end else begin
      wake_up_q <= raw & mask_q;
    end
  end

  assign wake_up_o = wake_up_q;

  a_no_spurious_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
    !(wake_core_we_i || wake_group_we_i) |=> wake_up_o == '0)
    else $error("Wake-up pulse without a preceding wake-up write");

endmodule : wake_up_unit
